/* rtl/flight_params.svh */
// ------------------------------------------------------------------------
// widths, rate and motor limits, per-axis PID gains and mixer shift
// ------------------------------------------------------------------------
`ifndef FLIGHT_PARAMS_SVH
`define FLIGHT_PARAMS_SVH

// word widths
`define FC_RATE_W       16
`define FC_MOTOR_W      12

// limits on the controller output and the motor command
`define FC_RATE_MIN     (-8000)
`define FC_RATE_MAX     8000
`define FC_MOTOR_MAX    4095

// rate scaling ahead of the quad-X mix
`define FC_MIX_SHIFT    2

// roll axis gains, signed multiplier then arithmetic right shift
`define FC_ROLL_KP          8'sd24
`define FC_ROLL_KI          8'sd6
`define FC_ROLL_KD          8'sd12
`define FC_ROLL_KP_SHIFT    4'd3
`define FC_ROLL_KI_SHIFT    4'd4
`define FC_ROLL_KD_SHIFT    4'd2

// pitch axis gains
`define FC_PITCH_KP         8'sd20
`define FC_PITCH_KI         8'sd5
`define FC_PITCH_KD         8'sd10
`define FC_PITCH_KP_SHIFT   4'd3
`define FC_PITCH_KI_SHIFT   4'd4
`define FC_PITCH_KD_SHIFT   4'd2

`endif

/* rtl/flight_pkg.sv */
// ------------------------------------------------------------------------
// rate, throttle and motor command types for the rate controller
// ------------------------------------------------------------------------
`include "flight_params.svh"

package flight_pkg;

	// signed body rate, also used for rate and angle errors
	typedef logic signed [`FC_RATE_W-1:0] rate_t;

	// inputs of one axis controller
	typedef struct packed {
		// from the outer attitude loop, feeds the integral term
		rate_t angle_error;
		rate_t target_rate;
		// measured rate from the gyro
		rate_t actual_rate;
	} axis_cmd_t;

	// collective throttle level
	typedef logic [`FC_MOTOR_W-1:0] throttle_t;

	// one motor command, 0 is stopped
	typedef logic [`FC_MOTOR_W-1:0] motor_t;

	// four motors of the X frame
	// m0 front right, m1 front left, m2 rear left, m3 rear right
	typedef struct packed {
		motor_t m0;
		motor_t m1;
		motor_t m2;
		motor_t m3;
	} motor_cmd_t;

endpackage

/* rtl/rate_pid.sv */
// ------------------------------------------------------------------------
// single-axis PID rate controller, five-cycle calculation sequence
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "flight_params.svh"

module rate_pid #(
	parameter int               RATE_MIN  = `FC_RATE_MIN,
	parameter int               RATE_MAX  = `FC_RATE_MAX,
	parameter logic signed [7:0] K_P       = 8'sd16,
	parameter logic signed [7:0] K_I       = 8'sd16,
	parameter logic signed [7:0] K_D       = 8'sd16,
	parameter logic [3:0]        K_P_SHIFT = 4'd4,
	parameter logic [3:0]        K_I_SHIFT = 4'd4,
	parameter logic [3:0]        K_D_SHIFT = 4'd4
) (
	input  logic                  us_clk,
	input  logic                  resetn,
	input  logic                  start,
	input  flight_pkg::axis_cmd_t cmd,
	output logic                  active,
	output logic                  done,
	output flight_pkg::rate_t     rate
);

	// sum of three saturated terms needs two extra bits
	localparam int SUM_W = `FC_RATE_W + 2;

	// saturation range of a scaled term
	localparam logic signed [31:0] SAT_MAX = 2 ** (`FC_RATE_W - 1) - 1;
	localparam logic signed [31:0] SAT_MIN = -(2 ** (`FC_RATE_W - 1));

	// one-hot state bits
	localparam int S_IDLE     = 0;
	localparam int S_CALC1    = 1;
	localparam int S_CALC2    = 2;
	localparam int S_CALC3    = 3;
	localparam int S_CALC4    = 4;
	localparam int S_COMPLETE = 5;
	localparam int NUM_STATES = 6;

	logic [NUM_STATES-1:0]   state;
	logic [NUM_STATES-1:0]   state_nxt;
	logic                    start_take;

	flight_pkg::axis_cmd_t   cmd_q;
	flight_pkg::rate_t       rate_err;
	flight_pkg::rate_t       prev_err;
	flight_pkg::rate_t       err_change;
	flight_pkg::rate_t       term_p;
	flight_pkg::rate_t       term_i;
	flight_pkg::rate_t       term_d;
	logic signed [SUM_W-1:0] sum;

	// value * gain, arithmetic shift, saturate to the rate word
	function automatic flight_pkg::rate_t scale_sat(
		input flight_pkg::rate_t  val,
		input logic signed [7:0]  k,
		input logic [3:0]         sh
	);
		logic signed [31:0] prod;
		prod = val * k;
		prod = prod >>> sh;
		if (prod > SAT_MAX)
			return SAT_MAX[`FC_RATE_W-1:0];
		else if (prod < SAT_MIN)
			return SAT_MIN[`FC_RATE_W-1:0];
		return prod[`FC_RATE_W-1:0];
	endfunction

	// start only counts once the previous done has gone
	assign start_take = state[S_IDLE] & ~active & start;

	always_comb begin
		state_nxt = '0;
		unique case (1'b1)
			state[S_IDLE]: begin
				if (start_take)
					state_nxt[S_CALC1] = 1'b1;
				else
					state_nxt[S_IDLE] = 1'b1;
			end
			state[S_CALC1]:    state_nxt[S_CALC2] = 1'b1;
			state[S_CALC2]:    state_nxt[S_CALC3] = 1'b1;
			state[S_CALC3]:    state_nxt[S_CALC4] = 1'b1;
			state[S_CALC4]:    state_nxt[S_COMPLETE] = 1'b1;
			state[S_COMPLETE]: state_nxt[S_IDLE] = 1'b1;
			default:           state_nxt[S_IDLE] = 1'b1;
		endcase
	end

	// control state and held outputs
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state    <= '0;
			state[S_IDLE] <= 1'b1;
			active   <= 1'b0;
			done     <= 1'b0;
			rate     <= '0;
			prev_err <= '0;
		end else begin
			state <= state_nxt;
			done  <= state[S_COMPLETE];

			if (start_take)
				active <= 1'b1;
			else if (done)
				active <= 1'b0;

			// kept for the next run's derivative
			if (state[S_CALC2])
				prev_err <= rate_err;

			if (state[S_COMPLETE]) begin
				if (sum < RATE_MIN)
					rate <= flight_pkg::rate_t'(RATE_MIN);
				else if (sum > RATE_MAX)
					rate <= flight_pkg::rate_t'(RATE_MAX);
				else
					rate <= sum[`FC_RATE_W-1:0];
			end
		end
	end

	// calculation pipeline, one step per state
	always_ff @(posedge us_clk) begin
		if (start_take)
			cmd_q <= cmd;

		if (state[S_CALC1]) begin
			rate_err <= cmd_q.target_rate - cmd_q.actual_rate;
			term_i   <= scale_sat(cmd_q.angle_error, K_I, K_I_SHIFT);
		end

		if (state[S_CALC2]) begin
			term_p     <= scale_sat(rate_err, K_P, K_P_SHIFT);
			err_change <= rate_err - prev_err;
		end

		if (state[S_CALC3])
			term_d <= scale_sat(err_change, K_D, K_D_SHIFT);

		// full width, clamped on the way out
		if (state[S_CALC4])
			sum <= term_p + term_i + term_d;
	end

endmodule

/* rtl/motor_mixer.sv */
// ------------------------------------------------------------------------
// quad-X motor mixer, two-stage pipeline with clamped motor outputs
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "flight_params.svh"

module motor_mixer (
	input  logic                   us_clk,
	input  logic                   resetn,
	input  logic                   roll_done,
	input  logic                   pitch_done,
	input  flight_pkg::rate_t      roll_rate,
	input  flight_pkg::rate_t      pitch_rate,
	input  flight_pkg::throttle_t  throttle,
	output flight_pkg::motor_cmd_t motors,
	output logic                   motor_valid
);

	// throttle plus two shifted rates always fits here
	localparam int MIX_W = `FC_RATE_W + 2;

	logic                    roll_ready;
	logic                    pitch_ready;
	logic                    roll_seen;
	logic                    pitch_seen;
	logic                    mix_go;

	logic signed [MIX_W-1:0] thr_s;
	logic signed [MIX_W-1:0] roll_s;
	logic signed [MIX_W-1:0] pitch_s;

	logic signed [MIX_W-1:0] mix_q [4];
	logic                    mix_valid;

	// limit a raw mix to the motor range
	function automatic flight_pkg::motor_t clamp_motor(
		input logic signed [MIX_W-1:0] v
	);
		if (v < 0)
			return '0;
		else if (v > `FC_MOTOR_MAX)
			return flight_pkg::motor_t'(`FC_MOTOR_MAX);
		return v[`FC_MOTOR_W-1:0];
	endfunction

	// an axis counts as delivered on its done or once recorded
	assign roll_seen  = roll_done | roll_ready;
	assign pitch_seen = pitch_done | pitch_ready;
	assign mix_go     = roll_seen & pitch_seen;

	// operands widened to the mix width
	assign thr_s   = MIX_W'(throttle);
	assign roll_s  = roll_rate >>> `FC_MIX_SHIFT;
	assign pitch_s = pitch_rate >>> `FC_MIX_SHIFT;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			roll_ready  <= 1'b0;
			pitch_ready <= 1'b0;
			mix_valid   <= 1'b0;
			motor_valid <= 1'b0;
			motors      <= '0;
		end else begin
			// both in, start a fresh round
			if (mix_go) begin
				roll_ready  <= 1'b0;
				pitch_ready <= 1'b0;
			end else begin
				roll_ready  <= roll_seen;
				pitch_ready <= pitch_seen;
			end

			mix_valid   <= mix_go;
			motor_valid <= mix_valid;

			// stage 2
			if (mix_valid) begin
				motors.m0 <= clamp_motor(mix_q[0]);
				motors.m1 <= clamp_motor(mix_q[1]);
				motors.m2 <= clamp_motor(mix_q[2]);
				motors.m3 <= clamp_motor(mix_q[3]);
			end
		end
	end

	// stage 1, raw X mixes
	always_ff @(posedge us_clk) begin
		if (mix_go) begin
			// front right
			mix_q[0] <= thr_s + pitch_s + roll_s;
			// front left
			mix_q[1] <= thr_s + pitch_s - roll_s;
			// rear left
			mix_q[2] <= thr_s - pitch_s - roll_s;
			// rear right
			mix_q[3] <= thr_s - pitch_s + roll_s;
		end
	end

endmodule

/* rtl/rate_controller_top.sv */
// ------------------------------------------------------------------------
// roll and pitch rate controllers feeding the quad-X motor mixer
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "flight_params.svh"

module rate_controller_top (
	input  logic                   us_clk,
	input  logic                   resetn,
	input  logic                   start,
	input  flight_pkg::throttle_t  throttle,
	input  flight_pkg::axis_cmd_t  roll_cmd,
	input  flight_pkg::axis_cmd_t  pitch_cmd,
	output logic                   busy,
	output flight_pkg::rate_t      roll_rate,
	output flight_pkg::rate_t      pitch_rate,
	output flight_pkg::motor_cmd_t motors,
	output logic                   motor_valid
);

	logic roll_active;
	logic pitch_active;
	logic roll_done;
	logic pitch_done;

	// roll axis
	rate_pid #(
		.RATE_MIN  (`FC_RATE_MIN),
		.RATE_MAX  (`FC_RATE_MAX),
		.K_P       (`FC_ROLL_KP),
		.K_I       (`FC_ROLL_KI),
		.K_D       (`FC_ROLL_KD),
		.K_P_SHIFT (`FC_ROLL_KP_SHIFT),
		.K_I_SHIFT (`FC_ROLL_KI_SHIFT),
		.K_D_SHIFT (`FC_ROLL_KD_SHIFT)
	) roll_pid_i (
		.us_clk (us_clk),
		.resetn (resetn),
		.start  (start),
		.cmd    (roll_cmd),
		.active (roll_active),
		.done   (roll_done),
		.rate   (roll_rate)
	);

	// pitch axis, same sequence with its own gains
	rate_pid #(
		.RATE_MIN  (`FC_RATE_MIN),
		.RATE_MAX  (`FC_RATE_MAX),
		.K_P       (`FC_PITCH_KP),
		.K_I       (`FC_PITCH_KI),
		.K_D       (`FC_PITCH_KD),
		.K_P_SHIFT (`FC_PITCH_KP_SHIFT),
		.K_I_SHIFT (`FC_PITCH_KI_SHIFT),
		.K_D_SHIFT (`FC_PITCH_KD_SHIFT)
	) pitch_pid_i (
		.us_clk (us_clk),
		.resetn (resetn),
		.start  (start),
		.cmd    (pitch_cmd),
		.active (pitch_active),
		.done   (pitch_done),
		.rate   (pitch_rate)
	);

	motor_mixer mixer_i (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.roll_done   (roll_done),
		.pitch_done  (pitch_done),
		.roll_rate   (roll_rate),
		.pitch_rate  (pitch_rate),
		.throttle    (throttle),
		.motors      (motors),
		.motor_valid (motor_valid)
	);

	// high while either axis is still running
	assign busy = roll_active | pitch_active;

endmodule

/* tb/rate_controller_props.sv */
// ------------------------------------------------------------------------
// concurrent assertions on the rate controller top-level timing
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module rate_controller_props (
	input logic                   us_clk,
	input logic                   resetn,
	input logic                   start,
	input logic                   busy,
	input logic                   motor_valid,
	input flight_pkg::rate_t      roll_rate,
	input flight_pkg::rate_t      pitch_rate,
	input flight_pkg::motor_cmd_t motors
);

	// set by the seventh edge after the start sample, seen on the eighth
	property valid_latency;
		@(posedge us_clk) disable iff (!resetn)
		(start && !busy) |-> ##8 $rose(motor_valid);
	endproperty

	property valid_single_cycle;
		@(posedge us_clk) disable iff (!resetn)
		$rose(motor_valid) |=> !motor_valid;
	endproperty

	// busy covers the six calculation cycles, then drops
	property busy_through_run;
		@(posedge us_clk) disable iff (!resetn)
		(start && !busy) |=> busy [*6] ##1 !busy;
	endproperty

	// from the second edge of a reset onwards
	property quiet_in_reset;
		@(posedge us_clk)
		(!resetn && $past(!resetn)) |-> (!busy && !motor_valid && roll_rate == '0
			&& pitch_rate == '0 && motors == '0);
	endproperty

	a_valid_latency: assert property (valid_latency)
		else $error("motor_valid did not rise seven edges after start");
	a_valid_single: assert property (valid_single_cycle)
		else $error("motor_valid held longer than one cycle");
	a_busy_run: assert property (busy_through_run)
		else $error("busy did not cover the run");
	a_reset_quiet: assert property (quiet_in_reset)
		else $error("outputs not cleared while in reset");

endmodule

/* tb/rate_controller_tb.sv */
// ------------------------------------------------------------------------
// testbench for the roll/pitch rate controller with quad-X mixer model
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "flight_params.svh"

module rate_controller_tb;

	localparam int N_RANDOM = 40;
	localparam int N_DERIV = 12;
	localparam int N_SAT = 4;
	localparam int N_CLAMP = 4;
	localparam int N_BUSY = 3;
	localparam int N_RESET = 3;
	localparam int TOTAL_RUNS = N_RANDOM + N_DERIV + N_SAT + N_CLAMP + N_BUSY + N_RESET;
	localparam int TIMEOUT_CYCLES = TOTAL_RUNS * 12 + 200;
	localparam int WAIT_LIMIT = 20;
	localparam logic [31:0] SEED = 32'h97b6;

	logic                   us_clk;
	logic                   resetn;
	logic                   start;
	flight_pkg::throttle_t  throttle;
	flight_pkg::axis_cmd_t  roll_cmd;
	flight_pkg::axis_cmd_t  pitch_cmd;
	logic                   busy;
	flight_pkg::rate_t      roll_rate;
	flight_pkg::rate_t      pitch_rate;
	flight_pkg::motor_cmd_t motors;
	logic                   motor_valid;

	logic [31:0]       lfsr_state;
	flight_pkg::rate_t prev_roll;
	flight_pkg::rate_t prev_pitch;
	int                cycle_count;
	int                run_count;
	int                check_count;
	int                error_count;
	int                test_checks;
	int                test_errors;

	rate_controller_top dut_i (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.throttle    (throttle),
		.roll_cmd    (roll_cmd),
		.pitch_cmd   (pitch_cmd),
		.busy        (busy),
		.roll_rate   (roll_rate),
		.pitch_rate  (pitch_rate),
		.motors      (motors),
		.motor_valid (motor_valid)
	);

	bind rate_controller_top rate_controller_props props_i (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.busy        (busy),
		.motor_valid (motor_valid),
		.roll_rate   (roll_rate),
		.pitch_rate  (pitch_rate),
		.motors      (motors)
	);

	initial begin
		us_clk = 1'b0;
		forever #10 us_clk = ~us_clk;
	end

	// hard stop if a run hangs
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge us_clk);
			cycle_count++;
		end
		$display("run timed out after %0d cycles without finishing the tests", cycle_count);
		$display("Finished with errors");
		$finish;
	end

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[31]};
		end
	endtask

	// small signed values, -1024 to 1023
	task automatic random_axis(output flight_pkg::axis_cmd_t c);
		logic [31:0] b;
		random_bits(11, b);
		c.angle_error = flight_pkg::rate_t'(int'(b) - 1024);
		random_bits(11, b);
		c.target_rate = flight_pkg::rate_t'(int'(b) - 1024);
		random_bits(11, b);
		c.actual_rate = flight_pkg::rate_t'(int'(b) - 1024);
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
			error_count++;
		end
	endtask

	// gain, arithmetic shift, then saturate to 16 bits signed
	function automatic int scaled_term(input int v, input int k, input int sh);
		int p;
		p = (v * k) >>> sh;
		if (p > 32767)
			p = 32767;
		else if (p < -32768)
			p = -32768;
		return p;
	endfunction

	task automatic model_axis(input flight_pkg::axis_cmd_t c, input int kp, input int ki,
		input int kd, input int sp, input int si, input int sd,
		inout flight_pkg::rate_t prev, output flight_pkg::rate_t rate);
		flight_pkg::rate_t err;
		flight_pkg::rate_t change;
		int sum;
		err = c.target_rate - c.actual_rate;
		change = err - prev;
		prev = err;
		sum = scaled_term(err, kp, sp) + scaled_term(c.angle_error, ki, si);
		sum = sum + scaled_term(change, kd, sd);
		if (sum > `FC_RATE_MAX)
			sum = `FC_RATE_MAX;
		else if (sum < `FC_RATE_MIN)
			sum = `FC_RATE_MIN;
		rate = flight_pkg::rate_t'(sum);
	endtask

	function automatic flight_pkg::motor_t motor_limit(input int v);
		if (v < 0)
			return '0;
		if (v > `FC_MOTOR_MAX)
			return flight_pkg::motor_t'(`FC_MOTOR_MAX);
		return flight_pkg::motor_t'(v);
	endfunction

	task automatic model_mix(input flight_pkg::rate_t rr, input flight_pkg::rate_t pr,
		input flight_pkg::throttle_t thr, output flight_pkg::motor_cmd_t m);
		int r;
		int p;
		int t;
		r = int'(rr) >>> `FC_MIX_SHIFT;
		p = int'(pr) >>> `FC_MIX_SHIFT;
		t = int'(thr);
		m.m0 = motor_limit(t + p + r);
		m.m1 = motor_limit(t + p - r);
		m.m2 = motor_limit(t - p - r);
		m.m3 = motor_limit(t - p + r);
	endtask

	// one start, optionally with extra starts while busy, then compare
	task automatic run_once(input flight_pkg::axis_cmd_t rc, input flight_pkg::axis_cmd_t pc,
		input flight_pkg::throttle_t thr, input bit extra_starts);
		flight_pkg::axis_cmd_t  junk;
		flight_pkg::rate_t      exp_roll;
		flight_pkg::rate_t      exp_pitch;
		flight_pkg::motor_cmd_t exp_m;
		int k;
		bit seen;
		@(negedge us_clk);
		roll_cmd = rc;
		pitch_cmd = pc;
		throttle = thr;
		start = 1'b1;
		model_axis(rc, `FC_ROLL_KP, `FC_ROLL_KI, `FC_ROLL_KD, `FC_ROLL_KP_SHIFT,
			`FC_ROLL_KI_SHIFT, `FC_ROLL_KD_SHIFT, prev_roll, exp_roll);
		model_axis(pc, `FC_PITCH_KP, `FC_PITCH_KI, `FC_PITCH_KD, `FC_PITCH_KP_SHIFT,
			`FC_PITCH_KI_SHIFT, `FC_PITCH_KD_SHIFT, prev_pitch, exp_pitch);
		model_mix(exp_roll, exp_pitch, thr, exp_m);
		run_count++;
		k = 0;
		seen = 1'b0;
		while (!seen && k < WAIT_LIMIT) begin
			@(negedge us_clk);
			k++;
			// these land while busy and must be dropped, the last one after done
			start = extra_starts && (k == 2 || k == 4 || k == 6);
			if (start) begin
				random_axis(junk);
				roll_cmd = junk;
				pitch_cmd = junk;
			end
			seen = motor_valid;
		end
		start = 1'b0;
		if (!seen) begin
			$display("no motor_valid within %0d cycles of start at %0t", WAIT_LIMIT, $time);
			error_count++;
		end else begin
			check_value("roll_rate", exp_roll, roll_rate);
			check_value("pitch_rate", exp_pitch, pitch_rate);
			check_value("motors.m0", exp_m.m0, motors.m0);
			check_value("motors.m1", exp_m.m1, motors.m1);
			check_value("motors.m2", exp_m.m2, motors.m2);
			check_value("motors.m3", exp_m.m3, motors.m3);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge us_clk);
	endtask

	task automatic expect_quiet(input int n);
		repeat (n) begin
			@(negedge us_clk);
			if (motor_valid) begin
				$display("unexpected extra motor_valid pulse at %0t", $time);
				error_count++;
			end
		end
	endtask

	// full-scale errors, roll up and pitch down or the reverse
	task automatic saturate_cmds(input bit positive, output flight_pkg::axis_cmd_t rc,
		output flight_pkg::axis_cmd_t pc);
		rc.angle_error = positive ? flight_pkg::rate_t'(32767) : flight_pkg::rate_t'(-32768);
		rc.target_rate = positive ? flight_pkg::rate_t'(16000) : flight_pkg::rate_t'(-16000);
		rc.actual_rate = -rc.target_rate;
		pc.angle_error = positive ? flight_pkg::rate_t'(-32768) : flight_pkg::rate_t'(32767);
		pc.target_rate = -rc.target_rate;
		pc.actual_rate = rc.target_rate;
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
		test_checks = check_count;
		test_errors = error_count;
	endtask

	initial begin
		flight_pkg::axis_cmd_t rc;
		flight_pkg::axis_cmd_t pc;
		logic [31:0] b;
		bit pos;
		lfsr_state = SEED;
		resetn = 1'b0;
		start = 1'b0;
		throttle = '0;
		roll_cmd = '0;
		pitch_cmd = '0;
		prev_roll = '0;
		prev_pitch = '0;
		run_count = 0;
		check_count = 0;
		error_count = 0;
		test_checks = 0;
		test_errors = 0;
		repeat (8) @(negedge us_clk);
		resetn = 1'b1;

		repeat (N_RANDOM) begin
			random_axis(rc);
			random_axis(pc);
			random_bits(12, b);
			run_once(rc, pc, flight_pkg::throttle_t'(b), 1'b0);
			random_bits(2, b);
			idle_cycles(int'(b));
		end
		finish_test("random single runs");

		// fixed target, drifting measured rate
		random_axis(rc);
		random_axis(pc);
		repeat (N_DERIV) begin
			random_bits(6, b);
			rc.actual_rate = rc.actual_rate + flight_pkg::rate_t'(int'(b) - 32);
			random_bits(6, b);
			pc.actual_rate = pc.actual_rate + flight_pkg::rate_t'(int'(b) - 32);
			run_once(rc, pc, 12'd2048, 1'b0);
		end
		finish_test("derivative memory");

		for (int i = 0; i < N_SAT; i++) begin
			pos = (i < N_SAT / 2);
			saturate_cmds(pos, rc, pc);
			run_once(rc, pc, 12'd2048, 1'b0);
			check_value("roll_rate", pos ? flight_pkg::rate_t'(`FC_RATE_MAX) :
				flight_pkg::rate_t'(`FC_RATE_MIN), roll_rate);
			check_value("pitch_rate", pos ? flight_pkg::rate_t'(`FC_RATE_MIN) :
				flight_pkg::rate_t'(`FC_RATE_MAX), pitch_rate);
		end
		finish_test("saturation");

		for (int i = 0; i < N_CLAMP; i++) begin
			pos = i[0];
			saturate_cmds(pos, rc, pc);
			if (i < 2) begin
				run_once(rc, pc, 12'd20, 1'b0);
				check_value(pos ? "motors.m1" : "motors.m3", '0, pos ? motors.m1 : motors.m3);
			end else begin
				run_once(rc, pc, 12'd4080, 1'b0);
				check_value(pos ? "motors.m3" : "motors.m1", `FC_MOTOR_MAX,
					pos ? motors.m3 : motors.m1);
			end
		end
		finish_test("motor clamping");

		repeat (N_BUSY) begin
			random_axis(rc);
			random_axis(pc);
			random_bits(12, b);
			run_once(rc, pc, flight_pkg::throttle_t'(b), 1'b1);
			expect_quiet(8);
		end
		finish_test("start while busy");

		// abort a run after the previous error has been stored
		random_axis(rc);
		random_axis(pc);
		@(negedge us_clk);
		roll_cmd = rc;
		pitch_cmd = pc;
		start = 1'b1;
		run_count++;
		@(negedge us_clk);
		start = 1'b0;
		idle_cycles(3);
		resetn = 1'b0;
		prev_roll = '0;
		prev_pitch = '0;
		idle_cycles(3);
		check_value("busy", 16'h0, 16'(busy));
		check_value("motor_valid", 16'h0, 16'(motor_valid));
		check_value("roll_rate", '0, roll_rate);
		check_value("pitch_rate", '0, pitch_rate);
		check_value("motors.m0", '0, motors.m0);
		check_value("motors.m1", '0, motors.m1);
		check_value("motors.m2", '0, motors.m2);
		check_value("motors.m3", '0, motors.m3);
		resetn = 1'b1;
		repeat (N_RESET - 1) begin
			random_axis(rc);
			random_axis(pc);
			random_bits(12, b);
			run_once(rc, pc, flight_pkg::throttle_t'(b), 1'b0);
		end
		finish_test("reset mid-run");

		$display("runs %0d, checks %0d, errors %0d", run_count, check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* build.f */
+incdir+rtl
rtl/flight_pkg.sv
rtl/rate_pid.sv
rtl/motor_mixer.sv
rtl/rate_controller_top.sv
tb/rate_controller_props.sv
tb/rate_controller_tb.sv
